// File: compile.f
+incdir+common
+incdir+verif
common/arith_pkg.sv
source/alu_comb.sv
source/mult_pipe.sv
divider/div_iter.sv
divider/div_signed.sv
source/arith_control.sv
source/arith_top.sv
verif/arith_tb.sv

// File: verif/arith_model.svh
// Arithmetic unit reference model: LFSR stepping and expected results per opcode
`ifndef ARITH_MODEL_SVH
`define ARITH_MODEL_SVH

// Fibonacci LFSR, taps 32, 22, 2 and 1; the new bit enters at bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

// Expected result word for one request
function automatic arith_pkg::word_t expected_result(input arith_pkg::op_e op,
                                                     input arith_pkg::word_t a,
                                                     input arith_pkg::word_t b);
  localparam int W = `ARITH_WIDTH;
  logic [4:0]     sh;
  logic [2*W-1:0] ext;
  longint         sa;
  longint         sb;
  longint         r;
  sh = b[4:0];
  sa = $signed(a);
  sb = $signed(b);
  case (op)
    arith_pkg::OP_ADD:  return a + b;
    arith_pkg::OP_SUB:  return a - b;
    arith_pkg::OP_AND:  return a & b;
    arith_pkg::OP_OR:   return a | b;
    arith_pkg::OP_XOR:  return a ^ b;
    // Flipping the sign bits turns a signed order into an unsigned one
    arith_pkg::OP_SLT:  return ({~a[W-1], a[W-2:0]} < {~b[W-1], b[W-2:0]}) ? 1 : 0;
    arith_pkg::OP_SLTU: return (a < b) ? 1 : 0;
    arith_pkg::OP_EQ:   return (a == b) ? 1 : 0;
    arith_pkg::OP_SHL:  return a << sh;
    arith_pkg::OP_SHR:  return a >> sh;
    arith_pkg::OP_SRA: begin
      ext = {{W{a[W-1]}}, a} >> sh;
      return ext[W-1:0];
    end
    arith_pkg::OP_MUL:  return a * b;
    arith_pkg::OP_DIVU: return a / b;
    arith_pkg::OP_REMU: return a % b;
    arith_pkg::OP_DIVS: begin
      r = sa / sb;
      return r[W-1:0];
    end
    default: begin
      // Floored modulo, sign of the divisor
      r = sa % sb;
      if ((r != 0) && ((r < 0) != (sb < 0))) begin
        r = r + sb;
      end
      return r[W-1:0];
    end
  endcase
endfunction

`endif

// File: verif/arith_tb.sv
// Arithmetic unit testbench with random requests checked against a model
`timescale 1ns/1ps
`include "arith_defines.svh"

module arith_tb;

  localparam int W          = `ARITH_WIDTH;
  localparam int N_EACH     = 16;
  localparam int N_MUL      = 24;
  localparam int NUM_OPS    = 11 * N_EACH + N_MUL + 4 * N_EACH + 4 + 2;
  localparam int MAX_CYCLES = NUM_OPS * (W + 4) + 5 + 200;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  go;
  arith_pkg::arith_req_t req;
  logic                  busy;
  logic                  done;
  arith_pkg::word_t      result;

  logic [31:0]      lfsr_state;
  int               cycles = 0;
  int               errors = 0;
  arith_pkg::word_t ra;
  arith_pkg::word_t rb;
  arith_pkg::word_t pick;
  arith_pkg::op_e   comb_ops [11] = '{arith_pkg::OP_ADD, arith_pkg::OP_SUB, arith_pkg::OP_AND,
                                      arith_pkg::OP_OR, arith_pkg::OP_XOR, arith_pkg::OP_SLT,
                                      arith_pkg::OP_SLTU, arith_pkg::OP_EQ, arith_pkg::OP_SHL,
                                      arith_pkg::OP_SHR, arith_pkg::OP_SRA};
  arith_pkg::op_e   div_ops [4] = '{arith_pkg::OP_DIVU, arith_pkg::OP_REMU,
                                    arith_pkg::OP_DIVS, arith_pkg::OP_REMS};

  `include "arith_model.svh"

  arith_top dut_i (
    .clk    (clk),
    .reset  (reset),
    .go     (go),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expect_val);
    if (got !== expect_val) begin
      errors = errors + 1;
      $display("Error %s: got 0x%0h, expected 0x%0h", name, got, expect_val);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic random_bits(input int n, output arith_pkg::word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[W-2:0], lfsr_state[0]};
    end
  endtask

  // Divisor of random size and sign that is never zero
  task automatic div_operands(output arith_pkg::word_t a, output arith_pkg::word_t b);
    arith_pkg::word_t k;
    arith_pkg::word_t s;
    random_bits(W, a);
    random_bits(W, b);
    random_bits(5, k);
    random_bits(1, s);
    b = b >> k;
    if (b == '0) begin
      b = 1;
    end
    if (s[0]) begin
      b = -b;
    end
  endtask

  // Drive one request on a falling edge once the unit is free
  task automatic issue_request(input arith_pkg::op_e op, input arith_pkg::word_t a,
                               input arith_pkg::word_t b);
    while (busy) begin
      @(negedge clk);
    end
    go  = 1'b1;
    req = '{op, a, b};
    @(negedge clk);
    go  = 1'b0;
    check_value("busy", busy, 1'b1);
  endtask

  task automatic run_op(input arith_pkg::op_e op, input arith_pkg::word_t a,
                        input arith_pkg::word_t b, input int exp_lat);
    arith_pkg::word_t expect_val;
    int               lat;
    expect_val = expected_result(op, a, b);
    issue_request(op, a, b);
    lat = 0;
    while (!done) begin
      @(negedge clk);
      lat++;
    end
    check_value("result", result, expect_val);
    check_value("latency", lat, exp_lat);
  endtask

  // A go during a division is dropped and gives no extra done
  // The dropped request asks for a remainder so a stolen opcode would show
  task automatic busy_drop_test;
    arith_pkg::word_t a;
    arith_pkg::word_t b;
    arith_pkg::word_t expect_val;
    int               lat;
    div_operands(a, b);
    a = a | 1;
    expect_val = expected_result(arith_pkg::OP_DIVU, a, b);
    issue_request(arith_pkg::OP_DIVU, a, b);
    lat = 0;
    repeat (3) begin
      @(negedge clk);
      lat++;
    end
    go  = 1'b1;
    req = '{arith_pkg::OP_REMU, b, a};
    @(negedge clk);
    lat++;
    go = 1'b0;
    while (!done) begin
      @(negedge clk);
      lat++;
    end
    check_value("result", result, expect_val);
    check_value("latency", lat, W + 3);
    repeat (W + 6) begin
      @(negedge clk);
      check_value("done", done, 1'b0);
    end
  endtask

  initial begin
    reset      = 1'b1;
    go         = 1'b0;
    req        = '0;
    lfsr_state = 32'ha2b;
    repeat (5) @(negedge clk);
    check_value("done", done, 1'b0);
    check_value("busy", busy, 1'b0);
    check_value("result", result, '0);
    reset = 1'b0;
    @(negedge clk);

    foreach (comb_ops[i]) begin
      repeat (N_EACH) begin
        random_bits(W, ra);
        random_bits(W, rb);
        random_bits(1, pick);
        // Equal operands now and then so OP_EQ also returns 1
        if (pick[0] && comb_ops[i] == arith_pkg::OP_EQ) begin
          rb = ra;
        end
        run_op(comb_ops[i], ra, rb, 1);
      end
    end

    repeat (N_MUL) begin
      random_bits(W, ra);
      random_bits(W, rb);
      run_op(arith_pkg::OP_MUL, ra, rb, 5);
    end

    foreach (div_ops[i]) begin
      repeat (N_EACH) begin
        div_operands(ra, rb);
        run_op(div_ops[i], ra, rb, (ra == '0) ? 3 : W + 3);
      end
      div_operands(ra, rb);
      run_op(div_ops[i], '0, rb, 3);
    end

    busy_drop_test();

    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: source/arith_top.sv
// Arithmetic unit top: controller with ALU, multiplier and divider engines
`timescale 1ns/1ps

module arith_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  arith_pkg::arith_req_t req,
  output logic                  busy,
  output logic                  done,
  output arith_pkg::word_t      result
);

  arith_pkg::arith_req_t op_reg;
  arith_pkg::word_t      alu_result;
  logic                  mul_start;
  logic                  mul_valid;
  arith_pkg::word_t      mul_product;
  logic                  div_start;
  logic                  div_signed_op;
  logic                  div_done;
  arith_pkg::word_t      div_quotient;
  arith_pkg::word_t      div_remainder;

  arith_control control_i (
    .clk           (clk),
    .reset         (reset),
    .go            (go),
    .req           (req),
    .alu_result    (alu_result),
    .mul_valid     (mul_valid),
    .mul_product   (mul_product),
    .div_done      (div_done),
    .div_quotient  (div_quotient),
    .div_remainder (div_remainder),
    .op_reg        (op_reg),
    .mul_start     (mul_start),
    .div_start     (div_start),
    .div_signed_op (div_signed_op),
    .busy          (busy),
    .done          (done),
    .result        (result)
  );

  alu_comb alu_i (
    .req    (op_reg),
    .result (alu_result)
  );

  mult_pipe mult_i (
    .clk     (clk),
    .reset   (reset),
    .start   (mul_start),
    .a       (op_reg.a),
    .b       (op_reg.b),
    .valid   (mul_valid),
    .product (mul_product)
  );

  div_signed div_i (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .signed_op (div_signed_op),
    .a         (op_reg.a),
    .b         (op_reg.b),
    .done      (div_done),
    .quotient  (div_quotient),
    .remainder (div_remainder)
  );

endmodule

// File: source/arith_control.sv
// Arithmetic controller: accepts one request, runs the chosen engine, returns the result
`timescale 1ns/1ps

module arith_control (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  go,
  input  arith_pkg::arith_req_t req,
  input  arith_pkg::word_t      alu_result,
  input  logic                  mul_valid,
  input  arith_pkg::word_t      mul_product,
  input  logic                  div_done,
  input  arith_pkg::word_t      div_quotient,
  input  arith_pkg::word_t      div_remainder,
  output arith_pkg::arith_req_t op_reg,
  output logic                  mul_start,
  output logic                  div_start,
  output logic                  div_signed_op,
  output logic                  busy,
  output logic                  done,
  output arith_pkg::word_t      result
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ALU,
    S_MUL,
    S_DIV
  } state_e;

  state_e state;
  logic   launch;
  logic   accept;
  logic   req_is_mul;
  logic   req_is_div;
  logic   op_is_rem;

  // Busy also covers the cycle where done is shown
  assign busy   = (state != S_IDLE) || done;
  assign accept = go && !busy;

  assign req_is_mul    = req.op == arith_pkg::OP_MUL;
  assign req_is_div    = req.op inside {arith_pkg::OP_DIVU, arith_pkg::OP_REMU,
                                        arith_pkg::OP_DIVS, arith_pkg::OP_REMS};
  assign op_is_rem     = op_reg.op inside {arith_pkg::OP_REMU, arith_pkg::OP_REMS};
  assign div_signed_op = op_reg.op inside {arith_pkg::OP_DIVS, arith_pkg::OP_REMS};

  always_ff @(posedge clk) begin
    if (accept) begin
      op_reg <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      launch    <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
      done      <= 1'b0;
      result    <= '0;
    end else begin
      mul_start <= 1'b0;
      div_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            if (req_is_mul) begin
              state  <= S_MUL;
              launch <= 1'b1;
            end else if (req_is_div) begin
              state  <= S_DIV;
              launch <= 1'b1;
            end else begin
              state <= S_ALU;
            end
          end
        end
        S_ALU: begin
          result <= alu_result;
          done   <= 1'b1;
          state  <= S_IDLE;
        end
        S_MUL: begin
          // Engine start goes out on the first cycle in this state
          mul_start <= launch;
          launch    <= 1'b0;
          if (mul_valid) begin
            result <= mul_product;
            done   <= 1'b1;
            state  <= S_IDLE;
          end
        end
        S_DIV: begin
          div_start <= launch;
          launch    <= 1'b0;
          if (div_done) begin
            result <= op_is_rem ? div_remainder : div_quotient;
            done   <= 1'b1;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // One done strobe per request
  a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done);

  // Done only closes a request that was in flight
  a_done_after_busy: assert property (@(posedge clk) disable iff (reset)
    done |-> $past(busy));

endmodule

// File: divider/div_signed.sv
// Signed divide wrapper: magnitudes into div_iter, result signs fixed on the way out
`timescale 1ns/1ps
`include "arith_defines.svh"

module div_signed (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic             signed_op,
  input  arith_pkg::word_t a,
  input  arith_pkg::word_t b,
  output logic             done,
  output arith_pkg::word_t quotient,
  output arith_pkg::word_t remainder
);

  localparam int W = `ARITH_WIDTH;

  logic             a_neg;
  logic             b_neg;
  arith_pkg::word_t a_mag;
  arith_pkg::word_t b_mag;
  logic             a_sign_q;
  logic             b_sign_q;
  arith_pkg::word_t b_mag_q;
  arith_pkg::word_t q_mag;
  arith_pkg::word_t r_mag;
  arith_pkg::word_t rem_adj;
  logic             sign_diff;

  // Unsigned mode never sees a negative operand
  assign a_neg = signed_op && a[W-1];
  assign b_neg = signed_op && b[W-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_sign_q <= 1'b0;
      b_sign_q <= 1'b0;
    end else if (start) begin
      a_sign_q <= a_neg;
      b_sign_q <= b_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      b_mag_q <= b_mag;
    end
  end

  div_iter div_iter_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .dividend  (a_mag),
    .divisor   (b_mag),
    .done      (done),
    .quotient  (q_mag),
    .remainder (r_mag)
  );

  assign sign_diff = a_sign_q ^ b_sign_q;

  // Quotient truncates toward zero
  assign quotient = sign_diff ? -q_mag : q_mag;

  // Remainder follows the divisor sign
  assign rem_adj   = (sign_diff && (r_mag != '0)) ? b_mag_q - r_mag : r_mag;
  assign remainder = b_sign_q ? -rem_adj : rem_adj;

endmodule

// File: divider/div_iter.sv
// Restoring divider, unsigned, one quotient bit per cycle
`timescale 1ns/1ps
`include "arith_defines.svh"

module div_iter (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  arith_pkg::word_t dividend,
  input  arith_pkg::word_t divisor,
  output logic             done,
  output arith_pkg::word_t quotient,
  output arith_pkg::word_t remainder
);

  localparam int W  = `ARITH_WIDTH;
  localparam int CW = `DIV_CNT_WIDTH;
  localparam logic [CW-1:0] LAST_CNT = CW'(W - 1);

  logic             running;
  logic             launch;
  logic             zero_dvd;
  logic             last;
  logic             fits;
  logic [W-1:0]     mask;
  logic [2*W-2:0]   divisor_sh;
  logic [W-1:0]     rem_acc;
  logic [W-1:0]     quot;
  logic [CW-1:0]    cnt;
  logic [W-1:0]     rem_next;
  logic [W-1:0]     quot_next;

  assign launch   = start && !running;
  assign zero_dvd = launch && (dividend == '0);
  assign last     = running && (cnt == LAST_CNT);

  // Trial subtraction against the shifted divisor
  assign fits      = divisor_sh <= {{(W-1){1'b0}}, rem_acc};
  assign rem_next  = fits ? rem_acc - divisor_sh[W-1:0] : rem_acc;
  assign quot_next = fits ? quot | mask : quot;

  always_ff @(posedge clk) begin
    if (reset) begin
      running   <= 1'b0;
      done      <= 1'b0;
      quotient  <= '0;
      remainder <= '0;
    end else begin
      done <= zero_dvd || last;
      if (zero_dvd) begin
        quotient  <= '0;
        remainder <= '0;
      end else if (last) begin
        // Final step lands straight in the outputs
        quotient  <= quot_next;
        remainder <= rem_next;
        running   <= 1'b0;
      end else if (launch) begin
        running <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      mask       <= {1'b1, {(W-1){1'b0}}};
      divisor_sh <= {divisor, {(W-1){1'b0}}};
      rem_acc    <= dividend;
      quot       <= '0;
      cnt        <= '0;
    end else if (running) begin
      mask       <= mask >> 1;
      divisor_sh <= divisor_sh >> 1;
      rem_acc    <= rem_next;
      quot       <= quot_next;
      cnt        <= cnt + 1'b1;
    end
  end

  // Division by zero is never requested
  a_divisor_nonzero: assert property (@(posedge clk) disable iff (reset)
    start |-> divisor != '0);

endmodule

// File: source/mult_pipe.sv
// Pipelined multiplier, three stages, low word of the product
`timescale 1ns/1ps
`include "arith_defines.svh"

module mult_pipe (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  arith_pkg::word_t a,
  input  arith_pkg::word_t b,
  output logic             valid,
  output arith_pkg::word_t product
);

  localparam int W      = `ARITH_WIDTH;
  localparam int STAGES = `MULT_STAGES;

  logic [STAGES-1:0] vld;
  arith_pkg::word_t  a_q;
  arith_pkg::word_t  b_q;
  logic [2*W-1:0]    full_q;

  // Valid travels with the data, one bit per stage
  always_ff @(posedge clk) begin
    if (reset) begin
      vld <= '0;
    end else begin
      vld <= {vld[STAGES-2:0], start};
    end
  end

  assign valid = vld[STAGES-1];

  always_ff @(posedge clk) begin
    if (start) begin
      a_q <= a;
      b_q <= b;
    end
    if (vld[0]) begin
      full_q <= {{W{1'b0}}, a_q} * {{W{1'b0}}, b_q};
    end
    if (vld[1]) begin
      product <= full_q[W-1:0];
    end
  end

endmodule

// File: source/alu_comb.sv
// Combinational ALU: arithmetic, logic, compare and shift operations
`timescale 1ns/1ps
`include "arith_defines.svh"

module alu_comb (
  input  arith_pkg::arith_req_t req,
  output arith_pkg::word_t      result
);

  localparam int SHW = $clog2(`ARITH_WIDTH);

  logic [SHW-1:0] shamt;

  // Shift distance is the low bits of b
  assign shamt = req.b[SHW-1:0];

  always_comb begin
    case (req.op)
      arith_pkg::OP_ADD:  result = req.a + req.b;
      arith_pkg::OP_SUB:  result = req.a - req.b;
      arith_pkg::OP_AND:  result = req.a & req.b;
      arith_pkg::OP_OR:   result = req.a | req.b;
      arith_pkg::OP_XOR:  result = req.a ^ req.b;
      arith_pkg::OP_SLT:  result = arith_pkg::word_t'($signed(req.a) < $signed(req.b));
      arith_pkg::OP_SLTU: result = arith_pkg::word_t'(req.a < req.b);
      arith_pkg::OP_EQ:   result = arith_pkg::word_t'(req.a == req.b);
      arith_pkg::OP_SHL:  result = req.a << shamt;
      arith_pkg::OP_SHR:  result = req.a >> shamt;
      arith_pkg::OP_SRA:  result = arith_pkg::word_t'($signed(req.a) >>> shamt);
      // Multi-cycle ops are answered by their own engines
      default:            result = '0;
    endcase
  end

endmodule

// File: common/arith_pkg.sv
// Arithmetic unit shared types: data word, opcodes and request
`include "arith_defines.svh"

package arith_pkg;

  typedef logic [`ARITH_WIDTH-1:0] word_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLT  = 4'd5,
    OP_SLTU = 4'd6,
    OP_EQ   = 4'd7,
    OP_SHL  = 4'd8,
    OP_SHR  = 4'd9,
    OP_SRA  = 4'd10,
    OP_MUL  = 4'd11,
    OP_DIVU = 4'd12,
    OP_REMU = 4'd13,
    OP_DIVS = 4'd14,
    OP_REMS = 4'd15
  } op_e;

  // One request as presented with go
  typedef struct packed {
    op_e   op;
    word_t a;
    word_t b;
  } arith_req_t;

endpackage

// File: common/arith_defines.svh
// Arithmetic unit widths and engine latencies
`ifndef ARITH_DEFINES_SVH
`define ARITH_DEFINES_SVH

// Operand and result width
`define ARITH_WIDTH 32

// Multiplier pipeline depth in cycles
`define MULT_STAGES 3

// Divider step counter, one extra bit so ARITH_WIDTH itself fits
`define DIV_CNT_WIDTH ($clog2(`ARITH_WIDTH) + 1)

`endif
